// File: files.f
+incdir+common
common/rv_pkg.sv
verilog/pipe_reg.sv
verilog/pipe_ctrl.sv
verilog/rv_regfile.sv
decode/rv_decoder.sv
execute/rv_alu.sv
verilog/rv_core.sv
dv/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_core \
    -f files.f -o tb_rv_core_sim \
    && ./obj_dir/tb_rv_core_sim | tee /dev/stderr \
    | grep -x "Verification passed" > /dev/null \
    && echo "Simulation ended with the pass message" \
    || { echo "Simulation did not end with the pass message"; exit 1; }

// File: dv/tb_rv_core.sv
// Directed testbench for rv_core, checks every retired instruction against a register model
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core;
    import rv_pkg::*;

    logic        clk;
    logic        rst_n_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_inst_i;
    logic        fetch_ready_o;
    logic        retire_valid_o;
    retire_t     retire_o;
    logic        retire_ready_i;

    logic [31:0] model_regs [32];
    logic [31:0] prog [$];
    logic [31:0] next_pc;
    integer      seed = 32'h0b9b82c5;
    int          cycle_count = 0;
    int          cycle_limit = 200;  // Grows by twice each program length
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          first_fetch_cyc;
    int          first_retire_cyc;
    bit          stall_seen;

    rv_core DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_inst_i   (fetch_inst_i),
        .fetch_ready_o  (fetch_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    // ISA semantics of the integer ops, selected by funct3 and the funct7 alternate bit
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0))
                                : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void model_exec(input logic [31:0] inst, input logic [31:0] pc,
                                       output logic we, output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'b0};
        we    = 1'b1;
        res   = '0;
        case (inst[6:0])
            `RV_OP_REG:   res = alu_ref(inst[14:12], inst[30], a, b);
            `RV_OP_IMM:   res = alu_ref(inst[14:12], inst[30] && (inst[14:12] == 3'd5), a, imm_i);
            `RV_OP_LUI:   res = imm_u;
            `RV_OP_AUIPC: res = pc + imm_u;
            default:      we = 1'b0;  // Unsupported opcode, no write
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_retire(input int idx);
        logic [31:0] inst;
        logic        exp_we;
        logic [31:0] exp_res;
        inst = prog[idx];
        model_exec(inst, next_pc, exp_we, exp_res);
        check_eq("retire_o.pc", next_pc, retire_o.pc);
        check_eq("retire_o.inst", inst, retire_o.inst);
        check_eq("retire_o.rd", {27'b0, inst[11:7]}, {27'b0, retire_o.rd});
        check_eq("retire_o.we", {31'b0, exp_we}, {31'b0, retire_o.we});
        if (exp_we) begin
            check_eq("retire_o.result", exp_res, retire_o.result);
            if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = exp_res;
        end
        next_pc = next_pc + 32'd4;
    endtask

    // Offers prog on the fetch port and checks each retire until all of it has retired
    task automatic run_program(input bit random_flow);
        int          n;
        int          fetched;
        int          retired;
        int          cyc;
        logic        fetch_fire;
        logic        retire_fire;
        logic [31:0] r;
        n           = prog.size();
        cycle_limit = cycle_limit + 2 * n;
        fetched     = 0;
        retired     = 0;
        cyc         = 0;
        fetch_fire  = 1'b0;
        while (retired < n) begin
            @(negedge clk);
            if (!fetch_valid_i || fetch_fire) begin  // Offer held until taken
                r = $random(seed);
                fetch_valid_i = (fetched < n) && (!random_flow || r[1:0] != 2'b00);
                fetch_inst_i  = (fetched < n) ? prog[fetched] : 32'h0;
            end
            r = $random(seed);
            retire_ready_i = !random_flow || ((cyc % 16) >= 5 && r[3:2] != 2'b00);
            #1;
            fetch_fire  = fetch_valid_i && fetch_ready_o;
            retire_fire = retire_valid_o && retire_ready_i;
            assert (fetched - retired <= 3) else begin
                $display("Pipeline holds %0d instructions, more than its three stages",
                         fetched - retired);
                test_errors++;
            end
            if (fetch_valid_i && !fetch_ready_o) begin
                stall_seen = 1'b1;
                assert (fetched - retired == 3) else begin
                    $display("Fetch stalled at %0t with only %0d instructions in flight",
                             $time, fetched - retired);
                    test_errors++;
                end
            end
            if (retire_fire) begin
                if (retired == 0) first_retire_cyc = cyc;
                check_retire(retired);
                retired++;
            end
            if (fetch_fire) begin
                if (fetched == 0) first_fetch_cyc = cyc;
                fetched++;
            end
            cyc++;
        end
        prog.delete();
    endtask

    task automatic random_inst(output logic [31:0] inst);
        logic [31:0] r;
        logic [31:0] q;
        logic [2:0]  f3;
        logic [11:0] imm;
        r  = $random(seed);
        q  = $random(seed);
        f3 = r[4:2];
        if (r[1] == 1'b0) begin
            inst = enc_r((f3 == 3'd0 || f3 == 3'd5) && r[5], r[20:16], r[15:11], f3, r[10:6]);
        end else if (r[0] == 1'b0) begin
            imm = q[11:0];
            if (f3 == 3'd1) imm = {7'b0, q[4:0]};
            if (f3 == 3'd5) imm = {1'b0, r[5], 5'b0, q[4:0]};
            inst = enc_i(imm, r[15:11], f3, r[10:6]);
        end else begin
            inst = enc_u(q[31:12], r[10:6], r[2] ? `RV_OP_AUIPC : `RV_OP_LUI);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-28s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_errors = total_errors + test_errors;
        test_errors  = 0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        #1;
        check_eq("retire_valid_o", 32'd0, {31'b0, retire_valid_o});
        check_eq("fetch_ready_o", 32'd1, {31'b0, fetch_ready_o});
        finish_test("reset state");
    endtask

    task automatic test_imm_forms();
        logic [31:0] r;
        logic [31:0] q;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          op;
        // Give every register a known value first
        for (int i = 1; i < 32; i++) begin
            r = $random(seed);
            if (i % 2 == 1) prog.push_back(enc_u(r[31:12], 5'(i), `RV_OP_LUI));
            else prog.push_back(enc_i(r[11:0], 5'd0, 3'd0, 5'(i)));
        end
        for (int k = 0; k < 18; k++) begin
            r   = $random(seed);
            q   = $random(seed);
            op  = k % 9;                      // 8 is srai
            f3  = (op == 8) ? 3'd5 : 3'(op);
            imm = q[11:0];
            if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, op == 8, 5'b0, q[4:0]};
            prog.push_back(enc_i(imm, r[4:0], f3, r[9:5]));
        end
        for (int k = 0; k < 2; k++) begin
            r = $random(seed);
            prog.push_back(enc_u(r[31:12], 5'(20 + k), `RV_OP_LUI));
            prog.push_back(enc_u(r[19:0], 5'(22 + k), `RV_OP_AUIPC));
        end
        run_program(1'b0);
        finish_test("immediate and upper forms");
    endtask

    task automatic test_reg_chains();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  src;
        logic [4:0]  other;
        int          op;
        // Each instruction reads the result produced d instructions earlier
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 12; k++) begin
                r     = $random(seed);
                op    = k % 10;
                f3    = (op == 8) ? 3'd0 : (op == 9) ? 3'd5 : 3'(op);
                alt   = (op >= 8);
                src   = 5'(10 + (k % d));
                other = 5'(1 + r[2:0]);
                if (k % 2 == 1) prog.push_back(enc_r(alt, src, other, f3, src));
                else prog.push_back(enc_r(alt, other, src, f3, src));
            end
        end
        run_program(1'b0);
        finish_test("register chains");
    endtask

    task automatic test_flow_control();
        logic [31:0] inst;
        stall_seen = 1'b0;
        for (int k = 0; k < 40; k++) begin
            random_inst(inst);
            prog.push_back(inst);
        end
        run_program(1'b1);
        assert (stall_seen) else begin
            $display("fetch_ready_o never went low while the pipeline was full");
            test_errors++;
        end
        finish_test("back-pressure and gaps");
    endtask

    task automatic test_x0_unknown();
        prog.push_back(enc_i(12'd123, 5'd0, 3'd0, 5'd0));
        prog.push_back(enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd0));
        prog.push_back(enc_r(1'b0, 5'd1, 5'd0, 3'd0, 5'd7));  // x0 read right after a write
        prog.push_back(enc_r(1'b0, 5'd0, 5'd0, 3'd4, 5'd8));
        prog.push_back({12'h004, 5'd1, 3'b010, 5'd9, 7'b0000011});  // Load opcode
        prog.push_back({7'h00, 5'd3, 5'd1, 3'b010, 5'd9, 7'b0100011});  // Store opcode
        prog.push_back(enc_i(12'd0, 5'd9, 3'd6, 5'd10));
        run_program(1'b0);
        finish_test("x0 and unknown opcodes");
    endtask

    task automatic test_latency();
        prog.push_back(enc_i(12'd1, 5'd3, 3'd0, 5'd3));
        run_program(1'b0);
        check_eq("retire latency in cycles", 32'd3, 32'(first_retire_cyc - first_fetch_cyc));
        finish_test("latency");
    endtask

    initial begin
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_inst_i   = 32'h0;
        retire_ready_i = 1'b1;
        next_pc        = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;

        test_reset();
        test_imm_forms();
        test_reg_chains();
        test_flow_control();
        test_x0_unknown();
        test_latency();

        $display("Tests run %0d, tests with errors %0d, check errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/rv_core.sv
// Core top level: instruction port in, retire port out, with decode, execute and write-back
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             fetch_valid_i,
    input  logic [31:0]      fetch_inst_i,
    output logic             fetch_ready_o,
    output logic             retire_valid_o,
    output rv_pkg::retire_t  retire_o,
    input  logic             retire_ready_i
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0]   fetch_pc_q;
    if_id_t                if_id_in;
    if_id_t                id_data;
    logic                  id_valid;
    alu_op_e               id_alu_op;
    logic [`RV_REG_AW-1:0] id_rs1;
    logic [`RV_REG_AW-1:0] id_rs2;
    logic [`RV_REG_AW-1:0] id_rd;
    logic                  id_rd_we;
    logic                  id_use_imm;
    logic                  id_use_pc;
    logic [`RV_XLEN-1:0]   id_imm;
    logic [`RV_XLEN-1:0]   rs1_rdata;
    logic [`RV_XLEN-1:0]   rs2_rdata;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    fwd_sel_e              rs1_sel;
    fwd_sel_e              rs2_sel;
    logic                  id_adv;
    logic                  ex_adv;
    logic                  wb_adv;
    id_ex_t                id_ex_in;
    id_ex_t                ex_data;
    logic                  ex_valid;
    logic [`RV_XLEN-1:0]   ex_result;
    ex_wb_t                ex_wb_in;

    // Instruction addresses count up on every accepted fetch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_pc_q <= `RV_RESET_PC;
        end else if (fetch_valid_i && fetch_ready_o) begin
            fetch_pc_q <= fetch_pc_q + `RV_XLEN'd4;
        end
    end

    assign if_id_in.pc   = fetch_pc_q;
    assign if_id_in.inst = fetch_inst_i;

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (fetch_valid_i),
        .in_data_i   (if_id_in),
        .in_ready_o  (fetch_ready_o),
        .out_valid_o (id_valid),
        .out_data_o  (id_data),
        .out_ready_i (id_adv)
    );

    rv_decoder u_decoder (
        .inst_i    (id_data.inst),
        .pc_i      (id_data.pc),
        .alu_op_o  (id_alu_op),
        .rs1_o     (id_rs1),
        .rs2_o     (id_rs2),
        .rd_o      (id_rd),
        .rd_we_o   (id_rd_we),
        .use_imm_o (id_use_imm),
        .use_pc_o  (id_use_pc),
        .imm_o     (id_imm)
    );

    // Written only when the retire port transfers
    rv_regfile u_regfile (
        .clk        (clk),
        .rs1_i      (id_rs1),
        .rs2_i      (id_rs2),
        .rs1_data_o (rs1_rdata),
        .rs2_data_o (rs2_rdata),
        .we_i       (wb_adv && retire_o.we),
        .rd_i       (retire_o.rd),
        .rd_data_i  (retire_o.result)
    );

    pipe_ctrl u_pipe_ctrl (
        .id_valid_i     (id_valid),
        .ex_valid_i     (ex_valid),
        .wb_valid_i     (retire_valid_o),
        .id_rs1_i       (id_rs1),
        .id_rs2_i       (id_rs2),
        .ex_rd_i        (ex_data.rd),
        .ex_we_i        (ex_data.we),
        .wb_rd_i        (retire_o.rd),
        .wb_we_i        (retire_o.we),
        .retire_ready_i (retire_ready_i),
        .id_adv_o       (id_adv),
        .ex_adv_o       (ex_adv),
        .wb_adv_o       (wb_adv),
        .rs1_sel_o      (rs1_sel),
        .rs2_sel_o      (rs2_sel)
    );

    always_comb begin
        case (rs1_sel)
            FWD_EX:  rs1_val = ex_result;
            FWD_WB:  rs1_val = retire_o.result;
            default: rs1_val = rs1_rdata;
        endcase
        case (rs2_sel)
            FWD_EX:  rs2_val = ex_result;
            FWD_WB:  rs2_val = retire_o.result;
            default: rs2_val = rs2_rdata;
        endcase
    end

    assign id_ex_in.pc     = id_data.pc;
    assign id_ex_in.inst   = id_data.inst;
    assign id_ex_in.rd     = id_rd;
    assign id_ex_in.we     = id_rd_we;
    assign id_ex_in.alu_op = id_alu_op;
    assign id_ex_in.op_a   = id_use_pc ? id_data.pc : rs1_val;
    assign id_ex_in.op_b   = id_use_imm ? id_imm : rs2_val;

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (id_valid),
        .in_data_i   (id_ex_in),
        .in_ready_o  (),
        .out_valid_o (ex_valid),
        .out_data_o  (ex_data),
        .out_ready_i (ex_adv)
    );

    rv_alu u_alu (
        .op_i     (ex_data.alu_op),
        .a_i      (ex_data.op_a),
        .b_i      (ex_data.op_b),
        .result_o (ex_result)
    );

    assign ex_wb_in.pc     = ex_data.pc;
    assign ex_wb_in.inst   = ex_data.inst;
    assign ex_wb_in.rd     = ex_data.rd;
    assign ex_wb_in.we     = ex_data.we;
    assign ex_wb_in.result = ex_result;

    // Write-back register drives the retire port directly
    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (ex_valid),
        .in_data_i   (ex_wb_in),
        .in_ready_o  (),
        .out_valid_o (retire_valid_o),
        .out_data_o  (retire_o),
        .out_ready_i (wb_adv)
    );

endmodule

// File: execute/rv_alu.sv
// Execute stage ALU, one combinational result per operation
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_alu (
    input  rv_pkg::alu_op_e     op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] result_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // Low five bits only

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU:   result_o = {{(`RV_XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = a_i + b_i;
        endcase
    end

endmodule

// File: decode/rv_decoder.sv
// Instruction decoder for the ALU, lui and auipc subset, feeding the decode stage operand muxes
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decoder (
    input  logic [31:0]           inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    output rv_pkg::alu_op_e       alu_op_o,
    output logic [`RV_REG_AW-1:0] rs1_o,
    output logic [`RV_REG_AW-1:0] rs2_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output logic                  rd_we_o,
    output logic                  use_imm_o,
    output logic                  use_pc_o,
    output logic [`RV_XLEN-1:0]   imm_o
);
    import rv_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];
    assign rd_o      = inst_i[11:7];
    assign rs1_o     = inst_i[19:15];
    assign rs2_o     = inst_i[24:20];

    assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};

    // alt picks sub or sra
    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        alu_op_o  = ALU_ADD;
        rd_we_o   = 1'b0;         // Unknown opcodes retire with no write
        use_imm_o = 1'b0;
        use_pc_o  = 1'b0;
        imm_o     = imm_i;
        case (opcode)
            `RV_OP_REG: begin
                rd_we_o  = 1'b1;
                alu_op_o = funct_op(funct3, funct7_b5);
            end
            `RV_OP_IMM: begin
                rd_we_o   = 1'b1;
                use_imm_o = 1'b1;
                alu_op_o  = funct_op(funct3, funct7_b5 && (funct3 == 3'b101));
            end
            `RV_OP_LUI: begin
                rd_we_o   = 1'b1;
                use_imm_o = 1'b1;
                alu_op_o  = ALU_PASS_B;
                imm_o     = imm_u;
            end
            `RV_OP_AUIPC: begin
                rd_we_o   = 1'b1;
                use_imm_o = 1'b1;
                use_pc_o  = 1'b1;
                alu_op_o  = ALU_ADD;
                imm_o     = imm_u;  // Added to the pc in execute
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/rv_regfile.sv
// Integer register file with two combinational read ports and one clocked write port
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    input  logic                  we_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic [`RV_XLEN-1:0]   rd_data_i
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

    always_ff @(posedge clk) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: verilog/pipe_ctrl.sv
// Pipeline flow control from the retire port backwards, plus operand forwarding for decode
`timescale 1ns/1ps
`include "rv_config.svh"

module pipe_ctrl (
    input  logic                  id_valid_i,
    input  logic                  ex_valid_i,
    input  logic                  wb_valid_i,
    input  logic [`RV_REG_AW-1:0] id_rs1_i,
    input  logic [`RV_REG_AW-1:0] id_rs2_i,
    input  logic [`RV_REG_AW-1:0] ex_rd_i,
    input  logic                  ex_we_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_i,
    input  logic                  wb_we_i,
    input  logic                  retire_ready_i,
    output logic                  id_adv_o,
    output logic                  ex_adv_o,
    output logic                  wb_adv_o,
    output rv_pkg::fwd_sel_e      rs1_sel_o,
    output rv_pkg::fwd_sel_e      rs2_sel_o
);
    import rv_pkg::*;

    logic rs1_hit_ex;
    logic rs1_hit_wb;
    logic rs2_hit_ex;
    logic rs2_hit_wb;

    // A stage moves on when the next one is empty or moving too
    assign wb_adv_o = wb_valid_i && retire_ready_i;
    assign ex_adv_o = ex_valid_i && (!wb_valid_i || wb_adv_o);
    assign id_adv_o = id_valid_i && (!ex_valid_i || ex_adv_o);

    assign rs1_hit_ex = ex_valid_i && ex_we_i && (ex_rd_i == id_rs1_i);
    assign rs1_hit_wb = wb_valid_i && wb_we_i && (wb_rd_i == id_rs1_i);
    assign rs2_hit_ex = ex_valid_i && ex_we_i && (ex_rd_i == id_rs2_i);
    assign rs2_hit_wb = wb_valid_i && wb_we_i && (wb_rd_i == id_rs2_i);

    // Youngest producer wins, x0 always reads the register file
    assign rs1_sel_o = (id_rs1_i == '0) ? FWD_RF :
                       rs1_hit_ex       ? FWD_EX :
                       rs1_hit_wb       ? FWD_WB : FWD_RF;
    assign rs2_sel_o = (id_rs2_i == '0) ? FWD_RF :
                       rs2_hit_ex       ? FWD_EX :
                       rs2_hit_wb       ? FWD_WB : FWD_RF;

endmodule

// File: verilog/pipe_reg.sv
// One-entry valid/ready pipeline register, instantiated per stage with that stage's payload type
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);
    logic     valid_q;
    payload_t data_q;

    assign in_ready_o  = !valid_q || out_ready_i;  // Empty or draining
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

// File: common/rv_pkg.sv
// Shared ALU encoding, forwarding selects and pipeline payload structs for the integer core
`include "rv_config.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    // Where a decode operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
    } if_id_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        alu_op_e               alu_op;
        logic [`RV_XLEN-1:0]   op_a;
        logic [`RV_XLEN-1:0]   op_b;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [31:0]           inst;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        logic [`RV_XLEN-1:0]   result;
    } ex_wb_t;

    // Retire port carries the write-back payload as is
    typedef ex_wb_t retire_t;

endpackage

// File: common/rv_config.svh
// Core-wide size, reset and opcode macros, included by the package and any RTL that needs widths
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and register file geometry
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_REG_NUM   32

// Address given to the first accepted instruction
`define RV_RESET_PC  32'h8000_0000

// Major opcodes handled by the decoder
`define RV_OP_REG    7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

`endif // RV_CONFIG_SVH
